// ==== bench/cpu16_soc_assertions.sv ====
// ##########################################################################
// APB master protocol assertions, bound into mem_unit
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module cpu16_soc_assertions (
    input wire clk,
    input wire reset,
    input wire psel,
    input wire penable,
    input wire pready
);

    // enable only inside a selected transfer
    penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset) penable |-> psel
    ) else $error("penable high while psel is low");

    // select holds through setup and wait states
    psel_held: assert property (
        @(posedge clk) disable iff (reset) (psel && !(penable && pready)) |=> psel
    ) else $error("psel dropped before the access completed");

    // bus idle once reset has been applied
    idle_after_reset: assert property (
        @(posedge clk) reset |=> (!psel && !penable)
    ) else $error("psel or penable active in the cycle after reset");

endmodule

bind mem_unit cpu16_soc_assertions apb_checks (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pready  (pready)
);

`default_nettype wire

// ==== bench/cpu16_soc_tb.sv ====
// ##########################################################################
// cpu16 SoC testbench, program table, loader, watchdog and result checks
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module cpu16_soc_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_SLOTS    = 8;
    localparam int MAX_ROWS     = 16;
    localparam int RESET_CYCLES = 5;
    // 12 cycles per instruction slot, so the pc can reach the last slot
    localparam int RUN_CYCLES   = 12 * cpu16_map_pkg::INSTR_DEPTH;
    localparam int TEST_CYCLES  = NUM_SLOTS + RESET_CYCLES + RUN_CYCLES + 8;
    localparam logic [7:0] GPIO_IMM = 8'(cpu16_map_pkg::GPIO_ADDR);

    logic                  clk;
    logic                  reset;
    logic                  prog_we;
    cpu16_map_pkg::pc_t    prog_addr;
    cpu16_isa_pkg::instr_t prog_data;
    cpu16_map_pkg::gpio_t  gpio;
    cpu16_map_pkg::pc_t    dbug_pc;

    string                 row_name [MAX_ROWS];
    cpu16_isa_pkg::instr_t row_prog [MAX_ROWS][NUM_SLOTS];
    cpu16_map_pkg::gpio_t  row_gpio [MAX_ROWS];
    int                    num_rows;
    int                    test_errors;
    int                    tests_passed;
    int                    tests_failed;

    cpu16_soc cpu16_soc_inst (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .gpio      (gpio),
        .dbug_pc   (dbug_pc)
    );

    // register form, low five bits carry the sub-operation or offset
    function automatic cpu16_isa_pkg::instr_t rr_instr(input cpu16_isa_pkg::opcode_t op,
            input cpu16_isa_pkg::reg_idx_t rd, input cpu16_isa_pkg::reg_idx_t ra,
            input logic [4:0] low5);
        return {op, rd, ra, low5};
    endfunction

    function automatic cpu16_isa_pkg::instr_t imm_instr(input cpu16_isa_pkg::opcode_t op,
            input cpu16_isa_pkg::reg_idx_t rd, input logic [7:0] imm8);
        return {op, rd, imm8};
    endfunction

    task automatic open_row(input string name, input cpu16_map_pkg::gpio_t expected);
        row_name[num_rows] = name;
        row_gpio[num_rows] = expected;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            row_prog[num_rows][s] = rr_instr(cpu16_isa_pkg::OP_NOP, 3'd0, 3'd0, 5'd0);
        end
        num_rows++;
    endtask

    task automatic set_slot(input int slot, input cpu16_isa_pkg::instr_t word);
        row_prog[num_rows-1][slot] = word;
    endtask

    // r2 = r2 op r3, then r2 goes out to the gpio register
    task automatic alu_row(input string name, input cpu16_isa_pkg::opcode_t op,
            input logic [4:0] sub, input logic [7:0] a, input logic [7:0] b,
            input cpu16_isa_pkg::word_t result);
        open_row(name, result[7:0]);
        set_slot(0, imm_instr(cpu16_isa_pkg::OP_MOVI, 3'd2, a));
        set_slot(1, imm_instr(cpu16_isa_pkg::OP_MOVI, 3'd3, b));
        set_slot(2, rr_instr(op, 3'd2, 3'd3, sub));
        set_slot(3, imm_instr(cpu16_isa_pkg::OP_MOVI, 3'd0, GPIO_IMM));
        set_slot(4, rr_instr(cpu16_isa_pkg::OP_SW, 3'd2, 3'd0, 5'd0));
    endtask

    task automatic build_table();
        // register i comes out of reset holding i
        open_row("reg_reset", 8'd5);
        set_slot(0, rr_instr(cpu16_isa_pkg::OP_MOV, 3'd1, 3'd5, 5'd0));
        set_slot(1, imm_instr(cpu16_isa_pkg::OP_MOVI, 3'd0, GPIO_IMM));
        set_slot(2, rr_instr(cpu16_isa_pkg::OP_SW, 3'd1, 3'd0, 5'd0));

        alu_row("or", cpu16_isa_pkg::OP_BIT, cpu16_isa_pkg::SUB_OR,
                8'h5C, 8'h33, 16'h005C | 16'h0033);
        alu_row("xor", cpu16_isa_pkg::OP_BIT, cpu16_isa_pkg::SUB_XOR,
                8'h5C, 8'h33, 16'h005C ^ 16'h0033);
        alu_row("and", cpu16_isa_pkg::OP_BIT, cpu16_isa_pkg::SUB_AND,
                8'h5C, 8'h33, 16'h005C & 16'h0033);
        alu_row("not", cpu16_isa_pkg::OP_BIT, cpu16_isa_pkg::SUB_NOT,
                8'h5C, 8'h33, ~16'h0033);
        alu_row("lshift", cpu16_isa_pkg::OP_BIT, cpu16_isa_pkg::SUB_LSHFT,
                8'h5C, 8'h03, 16'h005C << 3);
        alu_row("rshift", cpu16_isa_pkg::OP_BIT, cpu16_isa_pkg::SUB_RSHFT,
                8'hB4, 8'h02, 16'h00B4 >> 2);
        alu_row("uadd", cpu16_isa_pkg::OP_ARITH_U, cpu16_isa_pkg::SUB_UADD,
                8'hC8, 8'h5A, 16'h00C8 + 16'h005A);
        alu_row("usub", cpu16_isa_pkg::OP_ARITH_U, cpu16_isa_pkg::SUB_USUB,
                8'h20, 8'h45, 16'h0020 - 16'h0045);
        // immediate forms add the second register read
        alu_row("uaddi", cpu16_isa_pkg::OP_ARITH_U, cpu16_isa_pkg::SUB_UADDI,
                8'h11, 8'h22, 16'h0011 + 16'h0022);
        alu_row("sadd", cpu16_isa_pkg::OP_ARITH_S, cpu16_isa_pkg::SUB_SADD,
                8'h7F, 8'h7F, 16'h007F + 16'h007F);
        alu_row("ssub", cpu16_isa_pkg::OP_ARITH_S, cpu16_isa_pkg::SUB_SSUB,
                8'h10, 8'h30, 16'h0010 - 16'h0030);
        alu_row("ssubi", cpu16_isa_pkg::OP_ARITH_S, cpu16_isa_pkg::SUB_SSUBI,
                8'h40, 8'h25, 16'h0040 + 16'h0025);

        // base 3 plus offset 2 hits scratch word 5
        open_row("scratch_round_trip", 8'h5A);
        set_slot(0, imm_instr(cpu16_isa_pkg::OP_MOVI, 3'd4, 8'h5A));
        set_slot(1, imm_instr(cpu16_isa_pkg::OP_MOVI, 3'd6, 8'h03));
        set_slot(2, rr_instr(cpu16_isa_pkg::OP_SW, 3'd4, 3'd6, 5'd2));
        set_slot(3, rr_instr(cpu16_isa_pkg::OP_LW, 3'd7, 3'd6, 5'd2));
        set_slot(4, imm_instr(cpu16_isa_pkg::OP_MOVI, 3'd0, GPIO_IMM));
        set_slot(5, rr_instr(cpu16_isa_pkg::OP_SW, 3'd7, 3'd0, 5'd0));

        // gpio first set to 0x33, then overwritten by the unmapped load
        open_row("default_responder", 8'h00);
        set_slot(0, imm_instr(cpu16_isa_pkg::OP_MOVI, 3'd0, GPIO_IMM));
        set_slot(1, imm_instr(cpu16_isa_pkg::OP_MOVI, 3'd1, 8'h33));
        set_slot(2, rr_instr(cpu16_isa_pkg::OP_SW, 3'd1, 3'd0, 5'd0));
        set_slot(3, imm_instr(cpu16_isa_pkg::OP_MOVI, 3'd2, 8'h90));
        set_slot(4, rr_instr(cpu16_isa_pkg::OP_LW, 3'd1, 3'd2, 5'd0));
        set_slot(5, rr_instr(cpu16_isa_pkg::OP_SW, 3'd1, 3'd0, 5'd0));
    endtask

    task automatic check_gpio(input string name, input cpu16_map_pkg::gpio_t expected,
            input cpu16_map_pkg::gpio_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s gpio expected %02h actual %02h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_pc(input string name, input cpu16_map_pkg::pc_t expected,
            input cpu16_map_pkg::pc_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s pc expected %0d actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic run_test(input int row);
        test_errors = 0;
        @(posedge clk);
        reset <= 1'b1;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= cpu16_map_pkg::pc_t'(s);
            prog_data <= row_prog[row][s];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (RUN_CYCLES) @(posedge clk);
        // outputs settle well before the falling edge
        @(negedge clk);
        check_gpio(row_name[row], row_gpio[row], gpio);
        check_pc(row_name[row], cpu16_map_pkg::pc_t'(cpu16_map_pkg::INSTR_DEPTH - 1), dbug_pc);
        if (test_errors == 0) begin
            $display("PASS %s", row_name[row]);
            tests_passed++;
        end else begin
            $display("FAIL %s", row_name[row]);
            tests_failed++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (MAX_ROWS * TEST_CYCLES + 100));
        $display("watchdog expired before the last test finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        num_rows     = 0;
        tests_passed = 0;
        tests_failed = 0;
        build_table();
        for (int r = 0; r < num_rows; r++) begin
            run_test(r);
        end
        $display("tests run %0d, passed %0d, failed %0d", num_rows, tests_passed,
                 tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/cpu16_isa_pkg.sv
logic/cpu16_map_pkg.sv
logic/sync_ram.sv
logic/instr_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/mem_unit.sv
logic/gpio_apb.sv
logic/cpu_core.sv
logic/cpu16_soc.sv
bench/cpu16_soc_assertions.sv
bench/cpu16_soc_tb.sv

// ==== logic/alu.sv ====
// ##########################################################################
// combinational 16-bit ALU
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu16_isa_pkg::alu_op_t op,
    input  cpu16_isa_pkg::word_t   a,
    input  cpu16_isa_pkg::word_t   b,
    output cpu16_isa_pkg::word_t   c
);

    always_comb begin
        case (op)
            // moves and load/store base pass operand b
            cpu16_isa_pkg::ALU_LW,
            cpu16_isa_pkg::ALU_SW,
            cpu16_isa_pkg::ALU_MOV,
            cpu16_isa_pkg::ALU_MOVI:  c = b;
            cpu16_isa_pkg::ALU_OR:    c = a | b;
            cpu16_isa_pkg::ALU_XOR:   c = a ^ b;
            cpu16_isa_pkg::ALU_AND:   c = a & b;
            cpu16_isa_pkg::ALU_NOT:   c = ~b;
            cpu16_isa_pkg::ALU_LSHFT: c = a << b;
            cpu16_isa_pkg::ALU_RSHFT: c = a >> b;
            cpu16_isa_pkg::ALU_UADD,
            cpu16_isa_pkg::ALU_UADDI: c = a + b;
            cpu16_isa_pkg::ALU_USUB:  c = a - b;
            // immediate form adds as well
            cpu16_isa_pkg::ALU_SADD,
            cpu16_isa_pkg::ALU_SSUBI: c = cpu16_isa_pkg::word_t'($signed(a) + $signed(b));
            cpu16_isa_pkg::ALU_SSUB:  c = cpu16_isa_pkg::word_t'($signed(a) - $signed(b));
            // nop and bad ops
            default:                  c = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cpu16_isa_pkg.sv ====
// ##########################################################################
// instruction set types, field widths, opcodes and ALU operations
// ##########################################################################
`default_nettype none

package cpu16_isa_pkg;

    localparam int WORD_W    = 16;
    localparam int OPCODE_W  = 5;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 8;

    typedef logic [WORD_W-1:0]    word_t;
    // opcode [15:11], rd [10:8], ra [7:5], imm8 [7:0], simm5 [4:0]
    typedef logic [WORD_W-1:0]    instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [OPCODE_W-1:0] {
        OP_NOP     = 5'h00,
        OP_LW      = 5'h01,
        OP_SW      = 5'h02,
        OP_BIT     = 5'h03,
        OP_MOV     = 5'h04,
        OP_MOVI    = 5'h05,
        OP_ARITH_U = 5'h07,
        OP_ARITH_S = 5'h08
    } opcode_t;

    // sub-operations, carried in the simm5 field
    localparam logic [4:0] SUB_OR    = 5'h00;
    localparam logic [4:0] SUB_XOR   = 5'h01;
    localparam logic [4:0] SUB_AND   = 5'h02;
    localparam logic [4:0] SUB_NOT   = 5'h03;
    localparam logic [4:0] SUB_LSHFT = 5'h04;
    localparam logic [4:0] SUB_RSHFT = 5'h05;
    localparam logic [4:0] SUB_UADD  = 5'h00;
    localparam logic [4:0] SUB_USUB  = 5'h01;
    localparam logic [4:0] SUB_UADDI = 5'h02;
    localparam logic [4:0] SUB_SADD  = 5'h00;
    localparam logic [4:0] SUB_SSUB  = 5'h01;
    localparam logic [4:0] SUB_SSUBI = 5'h02;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_LW, ALU_SW, ALU_MOV, ALU_MOVI,
        ALU_OR, ALU_XOR, ALU_AND, ALU_NOT, ALU_LSHFT, ALU_RSHFT,
        ALU_UADD, ALU_USUB, ALU_UADDI,
        ALU_SADD, ALU_SSUB, ALU_SSUBI,
        ALU_BAD
    } alu_op_t;

endpackage

`default_nettype wire

// ==== logic/cpu16_map_pkg.sv ====
// ##########################################################################
// memory map, memory depths and GPIO types
// ##########################################################################
`default_nettype none

package cpu16_map_pkg;

    localparam int INSTR_DEPTH = 64;
    typedef logic [$clog2(INSTR_DEPTH)-1:0] pc_t;

    // scratch window, core local
    localparam int          SCRATCH_DEPTH = 64;
    localparam logic [15:0] SCRATCH_BASE  = 16'h0000;
    localparam logic [15:0] SCRATCH_LAST  = 16'h003F;

    // apb peripherals
    localparam logic [15:0] GPIO_ADDR  = 16'h00A0;
    localparam int          GPIO_WIDTH = 8;
    typedef logic [GPIO_WIDTH-1:0] gpio_t;

endpackage

`default_nettype wire

// ==== logic/cpu16_soc.sv ====
// ##########################################################################
// SoC top, instruction memory, core, APB decode and GPIO slave
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module cpu16_soc (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   prog_we,
    input  cpu16_map_pkg::pc_t    prog_addr,
    input  cpu16_isa_pkg::instr_t prog_data,
    output cpu16_map_pkg::gpio_t  gpio,
    output cpu16_map_pkg::pc_t    dbug_pc
);

    cpu16_map_pkg::pc_t    instr_addr;
    cpu16_isa_pkg::instr_t instr;
    cpu16_isa_pkg::word_t  paddr;
    cpu16_isa_pkg::word_t  pwdata;
    cpu16_isa_pkg::word_t  prdata;
    cpu16_isa_pkg::word_t  gpio_prdata;
    logic                  pwrite;
    logic                  psel;
    logic                  penable;
    logic                  pready;
    logic                  gpio_pready;
    logic                  gpio_sel;
    logic                  load;

    // program port owns the memory only while writing under reset
    assign load = reset && prog_we;

    sync_ram #(
        .word_type (cpu16_isa_pkg::instr_t),
        .DEPTH     (cpu16_map_pkg::INSTR_DEPTH)
    ) instr_mem (
        .clk   (clk),
        .we    (load),
        .addr  (load ? prog_addr : instr_addr),
        .wdata (prog_data),
        .rdata (instr)
    );

    cpu_core core (
        .clk        (clk),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr      (instr),
        .dbug_pc    (dbug_pc),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pwrite     (pwrite),
        .psel       (psel),
        .penable    (penable),
        .prdata     (prdata),
        .pready     (pready)
    );

    assign gpio_sel = (paddr == cpu16_map_pkg::GPIO_ADDR);

    // default responder reads zero with no wait states
    assign prdata = gpio_sel ? gpio_prdata : '0;
    assign pready = gpio_sel ? gpio_pready : (psel && penable);

    gpio_apb gpio0 (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel && gpio_sel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (gpio_prdata),
        .pready  (gpio_pready),
        .gpio    (gpio)
    );

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
// ##########################################################################
// multi-cycle core FSM, program counter and datapath
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire                   clk,
    input  wire                   reset,
    output cpu16_map_pkg::pc_t    instr_addr,
    input  cpu16_isa_pkg::instr_t instr,
    output cpu16_map_pkg::pc_t    dbug_pc,
    output cpu16_isa_pkg::word_t  paddr,
    output cpu16_isa_pkg::word_t  pwdata,
    output logic                  pwrite,
    output logic                  psel,
    output logic                  penable,
    input  cpu16_isa_pkg::word_t  prdata,
    input  wire                   pready
);

    typedef enum logic [2:0] {S_IF, S_R1, S_R2, S_ME, S_WB} state_t;

    state_t                  state;
    cpu16_map_pkg::pc_t      pc;
    cpu16_isa_pkg::instr_t   instr_q;
    cpu16_isa_pkg::word_t    opa;
    cpu16_isa_pkg::word_t    opb;
    cpu16_isa_pkg::reg_idx_t rd;
    cpu16_isa_pkg::reg_idx_t ra;
    cpu16_isa_pkg::word_t    imm8;
    cpu16_isa_pkg::word_t    simm5;
    cpu16_isa_pkg::alu_op_t  alu_op;
    cpu16_isa_pkg::word_t    alu_c;
    cpu16_isa_pkg::word_t    reg_rdata;
    cpu16_isa_pkg::word_t    mem_rdata;
    logic                    has_imm8;
    logic                    has_we;
    logic                    has_mem;
    logic                    has_mem_we;
    logic                    mem_req;
    logic                    mem_busy;

    assign instr_addr = pc;
    assign dbug_pc    = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IF;
            pc      <= '0;
            instr_q <= '0;
            mem_req <= 1'b0;
        end else begin
            case (state)
                S_IF: begin
                    instr_q <= instr;
                    // pc holds at the last slot
                    if (pc != cpu16_map_pkg::pc_t'(cpu16_map_pkg::INSTR_DEPTH - 1)) begin
                        pc <= pc + 1'b1;
                    end
                    state <= S_R1;
                end
                S_R1: begin
                    opa   <= reg_rdata;
                    state <= S_R2;
                end
                S_R2: begin
                    opb     <= has_imm8 ? imm8 : reg_rdata;
                    mem_req <= has_mem;
                    state   <= has_mem ? S_ME : S_WB;
                end
                S_ME: begin
                    mem_req <= 1'b0;
                    if (!mem_busy) begin
                        state <= S_WB;
                    end
                end
                default: state <= S_IF;
            endcase
        end
    end

    instr_decoder decoder (
        .instr      (instr_q),
        .rd         (rd),
        .ra         (ra),
        .imm8       (imm8),
        .simm5      (simm5),
        .alu_op     (alu_op),
        .has_imm8   (has_imm8),
        .has_we     (has_we),
        .has_mem    (has_mem),
        .has_mem_we (has_mem_we)
    );

    // rd on the first read, ra on the second
    reg_file regs (
        .clk   (clk),
        .reset (reset),
        .rs    ((state == S_R2) ? ra : rd),
        .rdata (reg_rdata),
        .we    (has_we && (state == S_WB)),
        .ws    (rd),
        .wdata (has_mem ? mem_rdata : alu_c)
    );

    alu alu_inst (
        .op (alu_op),
        .a  (opa),
        .b  (opb),
        .c  (alu_c)
    );

    mem_unit mmu (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_we    (has_mem_we && (state == S_ME)),
        .mem_addr  (alu_c + simm5),
        .mem_wdata (opa),
        .mem_busy  (mem_busy),
        .mem_rdata (mem_rdata),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pwrite    (pwrite),
        .psel      (psel),
        .penable   (penable),
        .prdata    (prdata),
        .pready    (pready)
    );

endmodule

`default_nettype wire

// ==== logic/gpio_apb.sv ====
// ##########################################################################
// APB slave with the GPIO output register
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module gpio_apb (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  psel,
    input  wire                  penable,
    input  wire                  pwrite,
    input  cpu16_isa_pkg::word_t pwdata,
    output cpu16_isa_pkg::word_t prdata,
    output logic                 pready,
    output cpu16_map_pkg::gpio_t gpio
);

    // zero wait state
    assign pready = psel && penable;
    assign prdata = cpu16_isa_pkg::word_t'(gpio);

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio <= '0;
        end else if (psel && penable && pwrite) begin
            gpio <= pwdata[cpu16_map_pkg::GPIO_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
// ##########################################################################
// instruction field decode and control flags
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  cpu16_isa_pkg::instr_t   instr,
    output cpu16_isa_pkg::reg_idx_t rd,
    output cpu16_isa_pkg::reg_idx_t ra,
    output cpu16_isa_pkg::word_t    imm8,
    output cpu16_isa_pkg::word_t    simm5,
    output cpu16_isa_pkg::alu_op_t  alu_op,
    output logic                    has_imm8,
    output logic                    has_we,
    output logic                    has_mem,
    output logic                    has_mem_we
);

    cpu16_isa_pkg::opcode_t opcode;
    logic [4:0]             sub;

    assign opcode = cpu16_isa_pkg::opcode_t'(instr[15:11]);
    assign sub    = instr[4:0];
    assign rd     = instr[10:8];
    assign ra     = instr[7:5];
    assign imm8   = cpu16_isa_pkg::word_t'(instr[7:0]);
    assign simm5  = cpu16_isa_pkg::word_t'(instr[4:0]);

    always_comb begin
        alu_op     = cpu16_isa_pkg::ALU_NOP;
        has_imm8   = 1'b0;
        has_we     = 1'b0;
        has_mem    = 1'b0;
        has_mem_we = 1'b0;
        case (opcode)
            cpu16_isa_pkg::OP_LW: begin
                alu_op  = cpu16_isa_pkg::ALU_LW;
                has_we  = 1'b1;
                has_mem = 1'b1;
            end
            cpu16_isa_pkg::OP_SW: begin
                alu_op     = cpu16_isa_pkg::ALU_SW;
                has_mem    = 1'b1;
                has_mem_we = 1'b1;
            end
            cpu16_isa_pkg::OP_MOV: begin
                alu_op = cpu16_isa_pkg::ALU_MOV;
                has_we = 1'b1;
            end
            cpu16_isa_pkg::OP_MOVI: begin
                alu_op   = cpu16_isa_pkg::ALU_MOVI;
                has_we   = 1'b1;
                has_imm8 = 1'b1;
            end
            cpu16_isa_pkg::OP_BIT: begin
                has_we = 1'b1;
                case (sub)
                    cpu16_isa_pkg::SUB_OR:    alu_op = cpu16_isa_pkg::ALU_OR;
                    cpu16_isa_pkg::SUB_XOR:   alu_op = cpu16_isa_pkg::ALU_XOR;
                    cpu16_isa_pkg::SUB_AND:   alu_op = cpu16_isa_pkg::ALU_AND;
                    cpu16_isa_pkg::SUB_NOT:   alu_op = cpu16_isa_pkg::ALU_NOT;
                    cpu16_isa_pkg::SUB_LSHFT: alu_op = cpu16_isa_pkg::ALU_LSHFT;
                    cpu16_isa_pkg::SUB_RSHFT: alu_op = cpu16_isa_pkg::ALU_RSHFT;
                    default:                  alu_op = cpu16_isa_pkg::ALU_BAD;
                endcase
            end
            cpu16_isa_pkg::OP_ARITH_U: begin
                has_we = 1'b1;
                case (sub)
                    cpu16_isa_pkg::SUB_UADD:  alu_op = cpu16_isa_pkg::ALU_UADD;
                    cpu16_isa_pkg::SUB_USUB:  alu_op = cpu16_isa_pkg::ALU_USUB;
                    cpu16_isa_pkg::SUB_UADDI: alu_op = cpu16_isa_pkg::ALU_UADDI;
                    default:                  alu_op = cpu16_isa_pkg::ALU_BAD;
                endcase
            end
            cpu16_isa_pkg::OP_ARITH_S: begin
                has_we = 1'b1;
                case (sub)
                    cpu16_isa_pkg::SUB_SADD:  alu_op = cpu16_isa_pkg::ALU_SADD;
                    cpu16_isa_pkg::SUB_SSUB:  alu_op = cpu16_isa_pkg::ALU_SSUB;
                    cpu16_isa_pkg::SUB_SSUBI: alu_op = cpu16_isa_pkg::ALU_SSUBI;
                    default:                  alu_op = cpu16_isa_pkg::ALU_BAD;
                endcase
            end
            // nop and unknown opcodes
            default: alu_op = cpu16_isa_pkg::ALU_NOP;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mem_unit.sv ====
// ##########################################################################
// load/store routing, scratch RAM and APB master state machine
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module mem_unit (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  mem_req,
    input  wire                  mem_we,
    input  cpu16_isa_pkg::word_t mem_addr,
    input  cpu16_isa_pkg::word_t mem_wdata,
    output logic                 mem_busy,
    output cpu16_isa_pkg::word_t mem_rdata,
    output cpu16_isa_pkg::word_t paddr,
    output cpu16_isa_pkg::word_t pwdata,
    output logic                 pwrite,
    output logic                 psel,
    output logic                 penable,
    input  cpu16_isa_pkg::word_t prdata,
    input  wire                  pready
);

    typedef enum logic [1:0] {M_IDLE, M_ACCESS, M_DONE} apb_state_t;

    apb_state_t           state;
    cpu16_isa_pkg::word_t offset;
    cpu16_isa_pkg::word_t scratch_rdata;
    cpu16_isa_pkg::word_t apb_rdata;
    logic                 scratch_sel;
    logic [$clog2(cpu16_map_pkg::SCRATCH_DEPTH)-1:0] scratch_addr;

    // window check on the offset covers any base
    assign offset       = mem_addr - cpu16_map_pkg::SCRATCH_BASE;
    assign scratch_sel  = offset <= (cpu16_map_pkg::SCRATCH_LAST - cpu16_map_pkg::SCRATCH_BASE);
    assign scratch_addr = offset[$clog2(cpu16_map_pkg::SCRATCH_DEPTH)-1:0];

    assign mem_busy  = mem_req || (state == M_ACCESS);
    assign mem_rdata = scratch_sel ? scratch_rdata : apb_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= M_IDLE;
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
            paddr   <= '0;
            pwdata  <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    // setup phase
                    if (mem_req && !scratch_sel) begin
                        paddr  <= mem_addr;
                        pwdata <= mem_wdata;
                        pwrite <= mem_we;
                        psel   <= 1'b1;
                        state  <= M_ACCESS;
                    end
                end
                M_ACCESS: begin
                    if (penable && pready) begin
                        apb_rdata <= prdata;
                        psel      <= 1'b0;
                        penable   <= 1'b0;
                        pwrite    <= 1'b0;
                        paddr     <= '0;
                        pwdata    <= '0;
                        state     <= M_DONE;
                    end else begin
                        penable <= 1'b1;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    sync_ram #(
        .word_type (cpu16_isa_pkg::word_t),
        .DEPTH     (cpu16_map_pkg::SCRATCH_DEPTH)
    ) scratch_ram (
        .clk   (clk),
        .we    (scratch_sel && mem_we),
        .addr  (scratch_addr),
        .wdata (mem_wdata),
        .rdata (scratch_rdata)
    );

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
// ##########################################################################
// eight-entry register file, one read port and one write port
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire                     reset,
    input  cpu16_isa_pkg::reg_idx_t rs,
    output cpu16_isa_pkg::word_t    rdata,
    input  wire                     we,
    input  cpu16_isa_pkg::reg_idx_t ws,
    input  cpu16_isa_pkg::word_t    wdata
);

    cpu16_isa_pkg::word_t regs [cpu16_isa_pkg::NUM_REGS];

    // register i resets to i
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cpu16_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= cpu16_isa_pkg::word_t'(i);
            end
        end else if (we) begin
            regs[ws] <= wdata;
        end
    end

    assign rdata = regs[rs];

endmodule

`default_nettype wire

// ==== logic/sync_ram.sv ====
// ##########################################################################
// single-port synchronous RAM, write first, registered read
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
    parameter type word_type = logic [15:0],
    parameter int  DEPTH     = 64
) (
    input  wire                     clk,
    input  wire                     we,
    input  wire [$clog2(DEPTH)-1:0] addr,
    input  word_type                wdata,
    output word_type                rdata
);

    word_type mem [DEPTH];

    // power-up contents, all zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the cpu16 SoC regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cpu16_soc_tb \
    -f flist.f -o cpu16_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/cpu16_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
